// File: verilog/nlc_defs.svh
`ifndef NLC_DEFS_SVH
`define NLC_DEFS_SVH

`define NLC_CHANNELS 4
`define NLC_CH_W 2
`define NLC_ADC_W 21
`define NLC_WORD_W 32

// Horner runs from coefficient 5 down to 0
`define NLC_ORDER 5

// Bank layout with coefficients at 0..5
`define NLC_IDX_W 3
`define NLC_IDX_NEG_MEAN 6
`define NLC_IDX_RECIP 7

`endif

// File: verilog/nlc_pkg.sv
package nlc_pkg;

	typedef enum logic [1:0] {
		CONVERT,
		ADD,
		MUL
	} arith_op_t;

	// One arithmetic operation per step except EMIT
	typedef enum logic [2:0] {
		IDLE,
		CONV,
		NORM_ADD,
		NORM_MUL,
		HORNER_MUL,
		HORNER_ADD,
		EMIT
	} seq_step_t;

endpackage

// File: verilog/arith_if.sv
`timescale 1ns/1ps
`include "nlc_defs.svh"

interface arith_if;
	import nlc_pkg::*;

	logic req; // One cycle, only when nothing outstanding
	arith_op_t op;
	logic [`NLC_WORD_W-1:0] a;
	logic [`NLC_WORD_W-1:0] b;
	logic done;
	logic [`NLC_WORD_W-1:0] result;

	modport master (output req, op, a, b, input done, result);
	modport slave (input req, op, a, b, output done, result);

endinterface

// File: verilog/coef_bank.sv
`timescale 1ns/1ps
`include "nlc_defs.svh"

module coef_bank (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic [`NLC_CH_W-1:0] wr_ch,
	input logic [`NLC_IDX_W-1:0] wr_idx,
	input logic [`NLC_WORD_W-1:0] wr_data,
	input logic [`NLC_CH_W-1:0] rd_ch,
	input logic [`NLC_IDX_W-1:0] rd_idx,
	output logic [`NLC_WORD_W-1:0] rd_data
);

	localparam int WORDS = 2 ** `NLC_IDX_W;

	// Coefficients 0..5, then negative mean and reciprocal deviation
	logic [`NLC_WORD_W-1:0] mem [`NLC_CHANNELS][WORDS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < `NLC_CHANNELS; c++) begin
				for (int i = 0; i < WORDS; i++) begin
					mem[c][i] <= '0;
				end
			end
		end else if (wr) begin
			mem[wr_ch][wr_idx] <= wr_data;
		end
	end

	assign rd_data = mem[rd_ch][rd_idx]; // Combinational read

endmodule

// File: verilog/arith_port.sv
`timescale 1ns/1ps
`include "nlc_defs.svh"

module arith_port (
	input logic clk,
	input logic rst,
	arith_if.slave arith,
	output logic conv_req,
	output logic [`NLC_ADC_W-1:0] conv_in,
	input logic conv_done,
	input logic [`NLC_WORD_W-1:0] conv_out,
	output logic add_req,
	output logic [`NLC_WORD_W-1:0] add_a,
	output logic [`NLC_WORD_W-1:0] add_b,
	input logic add_done,
	input logic [`NLC_WORD_W-1:0] add_out,
	output logic mul_req,
	output logic [`NLC_WORD_W-1:0] mul_a,
	output logic [`NLC_WORD_W-1:0] mul_b,
	input logic mul_done,
	input logic [`NLC_WORD_W-1:0] mul_out
);
	import nlc_pkg::*;

	logic pending;
	arith_op_t pend_op;
	logic [`NLC_WORD_W-1:0] pend_a;
	logic [`NLC_WORD_W-1:0] pend_b;
	logic unit_done;
	logic [`NLC_WORD_W-1:0] unit_out;
	logic done_q;
	logic [`NLC_WORD_W-1:0] result_q;

	// Only the unit that was asked may answer
	always_comb begin
		unit_done = 1'b0;
		unit_out = mul_out;
		case (pend_op)
			CONVERT: begin
				unit_done = pending && conv_done;
				unit_out = conv_out;
			end
			ADD: begin
				unit_done = pending && add_done;
				unit_out = add_out;
			end
			default: unit_done = pending && mul_done;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			conv_req <= 1'b0;
			add_req <= 1'b0;
			mul_req <= 1'b0;
			done_q <= 1'b0;
		end else begin
			conv_req <= arith.req && arith.op == CONVERT;
			add_req <= arith.req && arith.op == ADD;
			mul_req <= arith.req && arith.op == MUL;
			done_q <= unit_done;
			if (arith.req)
				pending <= 1'b1;
			else if (unit_done)
				pending <= 1'b0;
		end
	end

	// Operands held for the unit until it answers
	always_ff @(posedge clk) begin
		if (arith.req) begin
			pend_op <= arith.op;
			pend_a <= arith.a;
			pend_b <= arith.b;
		end
		if (unit_done)
			result_q <= unit_out;
	end

	assign conv_in = pend_a[`NLC_ADC_W-1:0];
	assign add_a = pend_a;
	assign add_b = pend_b;
	assign mul_a = pend_a;
	assign mul_b = pend_b;

	assign arith.done = done_q;
	assign arith.result = result_q;

endmodule

// File: verilog/nlc_sequencer.sv
`timescale 1ns/1ps
`include "nlc_defs.svh"

module nlc_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [`NLC_CHANNELS-1:0][`NLC_ADC_W-1:0] x_adc,
	output logic [`NLC_CH_W-1:0] rd_ch,
	output logic [`NLC_IDX_W-1:0] rd_idx,
	input logic [`NLC_WORD_W-1:0] rd_data,
	arith_if.master arith,
	output logic busy,
	output logic result_valid,
	output logic [`NLC_CH_W-1:0] result_ch,
	output logic [`NLC_WORD_W-1:0] result
);
	import nlc_pkg::*;

	seq_step_t step;
	logic issued; // Request of this step already sent
	logic [`NLC_CH_W-1:0] ch;
	logic [`NLC_IDX_W-1:0] k;
	logic [`NLC_CHANNELS-1:0][`NLC_ADC_W-1:0] x_cap;
	logic [`NLC_WORD_W-1:0] norm;
	logic [`NLC_WORD_W-1:0] acc;
	logic last_coef;

	assign rd_ch = ch;
	assign last_coef = k == '0;

	assign arith.req = !issued &&
		step inside {CONV, NORM_ADD, NORM_MUL, HORNER_MUL, HORNER_ADD};

	// Operands per step
	always_comb begin
		arith.op = ADD;
		arith.a = acc;
		arith.b = rd_data;
		case (step)
			CONV: begin
				arith.op = CONVERT;
				arith.a = {{(`NLC_WORD_W - `NLC_ADC_W){1'b0}}, x_cap[ch]};
				arith.b = '0;
			end
			NORM_ADD: arith.a = norm;
			NORM_MUL: begin
				arith.op = MUL;
				arith.a = norm;
			end
			HORNER_MUL: begin
				arith.op = MUL;
				arith.b = norm;
			end
			default: ;
		endcase
	end

	// Bank word for the step
	always_comb begin
		case (step)
			CONV: rd_idx = `NLC_IDX_W'(`NLC_ORDER); // Top coefficient seeds acc
			NORM_ADD: rd_idx = `NLC_IDX_W'(`NLC_IDX_NEG_MEAN);
			NORM_MUL: rd_idx = `NLC_IDX_W'(`NLC_IDX_RECIP);
			default: rd_idx = k;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= IDLE;
			issued <= 1'b0;
			ch <= '0;
			k <= '0;
			busy <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			if (arith.req)
				issued <= 1'b1;
			case (step)
				IDLE: if (start) begin
					ch <= '0;
					busy <= 1'b1;
					step <= CONV;
				end
				CONV: if (issued && arith.done) begin
					issued <= 1'b0;
					step <= NORM_ADD;
				end
				NORM_ADD: if (issued && arith.done) begin
					issued <= 1'b0;
					step <= NORM_MUL;
				end
				NORM_MUL: if (issued && arith.done) begin
					issued <= 1'b0;
					k <= `NLC_IDX_W'(`NLC_ORDER - 1);
					step <= HORNER_MUL;
				end
				HORNER_MUL: if (issued && arith.done) begin
					issued <= 1'b0;
					step <= HORNER_ADD;
				end
				HORNER_ADD: if (issued && arith.done) begin
					issued <= 1'b0;
					if (last_coef) begin
						result_valid <= 1'b1;
						step <= EMIT;
					end else begin
						k <= k - 1'b1;
						step <= HORNER_MUL;
					end
				end
				EMIT: begin
					if (ch == `NLC_CH_W'(`NLC_CHANNELS - 1)) begin
						busy <= 1'b0;
						step <= IDLE;
					end else begin
						ch <= ch + 1'b1;
						step <= CONV;
					end
				end
				default: step <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (step == IDLE && start)
			x_cap <= x_adc; // Whole frame at once
		if (step == CONV && arith.req)
			acc <= rd_data;
		if (arith.done && step inside {CONV, NORM_ADD, NORM_MUL})
			norm <= arith.result;
		if (arith.done && step inside {HORNER_MUL, HORNER_ADD})
			acc <= arith.result;
		if (step == HORNER_ADD && issued && arith.done && last_coef) begin
			result <= arith.result;
			result_ch <= ch;
		end
	end

endmodule

// File: verilog/nlc_top.sv
`timescale 1ns/1ps
`include "nlc_defs.svh"

module nlc_top (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [`NLC_CHANNELS-1:0][`NLC_ADC_W-1:0] x_adc,
	output logic busy,
	output logic result_valid,
	output logic [`NLC_CH_W-1:0] result_ch,
	output logic [`NLC_WORD_W-1:0] result,
	input logic coef_wr,
	input logic [`NLC_CH_W-1:0] coef_ch,
	input logic [`NLC_IDX_W-1:0] coef_idx,
	input logic [`NLC_WORD_W-1:0] coef_data,
	output logic conv_req,
	output logic [`NLC_ADC_W-1:0] conv_in,
	input logic conv_done,
	input logic [`NLC_WORD_W-1:0] conv_out,
	output logic add_req,
	output logic [`NLC_WORD_W-1:0] add_a,
	output logic [`NLC_WORD_W-1:0] add_b,
	input logic add_done,
	input logic [`NLC_WORD_W-1:0] add_out,
	output logic mul_req,
	output logic [`NLC_WORD_W-1:0] mul_a,
	output logic [`NLC_WORD_W-1:0] mul_b,
	input logic mul_done,
	input logic [`NLC_WORD_W-1:0] mul_out
);

	logic [`NLC_CH_W-1:0] rd_ch;
	logic [`NLC_IDX_W-1:0] rd_idx;
	logic [`NLC_WORD_W-1:0] rd_data;

	arith_if arith ();

	coef_bank bank0 (
		.clk(clk),
		.rst(rst),
		.wr(coef_wr),
		.wr_ch(coef_ch),
		.wr_idx(coef_idx),
		.wr_data(coef_data),
		.rd_ch(rd_ch),
		.rd_idx(rd_idx),
		.rd_data(rd_data)
	);

	nlc_sequencer seq0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.x_adc(x_adc),
		.rd_ch(rd_ch),
		.rd_idx(rd_idx),
		.rd_data(rd_data),
		.arith(arith.master),
		.busy(busy),
		.result_valid(result_valid),
		.result_ch(result_ch),
		.result(result)
	);

	// Single request in flight toward the three units
	arith_port port0 (
		.clk(clk),
		.rst(rst),
		.arith(arith.slave),
		.conv_req(conv_req),
		.conv_in(conv_in),
		.conv_done(conv_done),
		.conv_out(conv_out),
		.add_req(add_req),
		.add_a(add_a),
		.add_b(add_b),
		.add_done(add_done),
		.add_out(add_out),
		.mul_req(mul_req),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.mul_done(mul_done),
		.mul_out(mul_out)
	);

endmodule

// File: sim/arith_models.sv
`timescale 1ns/1ps
`include "nlc_defs.svh"

module arith_models (
	input logic clk,
	input logic rst,
	input logic [2:0][3:0] latency, // Converter, adder, multiplier
	input logic conv_req,
	input logic [`NLC_ADC_W-1:0] conv_in,
	output logic conv_done,
	output logic [`NLC_WORD_W-1:0] conv_out,
	input logic add_req,
	input logic [`NLC_WORD_W-1:0] add_a,
	input logic [`NLC_WORD_W-1:0] add_b,
	output logic add_done,
	output logic [`NLC_WORD_W-1:0] add_out,
	input logic mul_req,
	input logic [`NLC_WORD_W-1:0] mul_a,
	input logic [`NLC_WORD_W-1:0] mul_b,
	output logic mul_done,
	output logic [`NLC_WORD_W-1:0] mul_out
);

	logic [2:0] req;
	logic [2:0] done;
	logic [2:0][3:0] count;
	logic [2:0][`NLC_WORD_W-1:0] value;
	logic [2:0][`NLC_WORD_W-1:0] held;

	assign req = {mul_req, add_req, conv_req};
	assign value[0] = {{(`NLC_WORD_W - `NLC_ADC_W){1'b0}}, conv_in};
	assign value[1] = add_a + add_b;
	assign value[2] = mul_a * mul_b; // Low word of the product
	assign {mul_done, add_done, conv_done} = done;
	assign conv_out = held[0];
	assign add_out = held[1];
	assign mul_out = held[2];

	always_ff @(posedge clk) begin
		for (int u = 0; u < 3; u++) begin
			done[u] <= 1'b0;
			if (rst) begin
				count[u] <= '0;
			end else if (req[u]) begin
				count[u] <= latency[u];
				held[u] <= value[u];
			end else if (count[u] != 4'd0) begin
				count[u] <= count[u] - 1'b1;
				done[u] <= count[u] == 4'd1;
			end
		end
	end

endmodule

// File: sim/tb_nlc.sv
`timescale 1ns/1ps
`include "nlc_defs.svh"

module tb_nlc;

	localparam int ROWS = 7;
	localparam int WORDS = 2 ** `NLC_IDX_W;
	localparam int LIMIT = 400; // Cycles allowed per result

	logic clk;
	logic rst;
	logic start;
	logic [`NLC_CHANNELS-1:0][`NLC_ADC_W-1:0] x_adc;
	logic busy;
	logic result_valid;
	logic [`NLC_CH_W-1:0] result_ch;
	logic [`NLC_WORD_W-1:0] result;
	logic coef_wr;
	logic [`NLC_CH_W-1:0] coef_ch;
	logic [`NLC_IDX_W-1:0] coef_idx;
	logic [`NLC_WORD_W-1:0] coef_data;
	logic conv_req;
	logic [`NLC_ADC_W-1:0] conv_in;
	logic conv_done;
	logic [`NLC_WORD_W-1:0] conv_out;
	logic add_req;
	logic [`NLC_WORD_W-1:0] add_a;
	logic [`NLC_WORD_W-1:0] add_b;
	logic add_done;
	logic [`NLC_WORD_W-1:0] add_out;
	logic mul_req;
	logic [`NLC_WORD_W-1:0] mul_a;
	logic [`NLC_WORD_W-1:0] mul_b;
	logic mul_done;
	logic [`NLC_WORD_W-1:0] mul_out;
	logic [2:0][3:0] latency;

	logic [`NLC_WORD_W-1:0] shadow [`NLC_CHANNELS][WORDS]; // Expected bank contents
	logic [`NLC_WORD_W-1:0] prev [`NLC_CHANNELS];
	logic [31:0] lfsr;
	int checks;
	int errors;
	int timeouts;

	string names [ROWS];
	logic [`NLC_CHANNELS-1:0][`NLC_ADC_W-1:0] samples [ROWS];
	logic [`NLC_CH_W-1:0] wr_chs [ROWS];
	logic [31:0] bases [ROWS];
	logic [`NLC_CHANNELS-1:0] keep [ROWS]; // Channels equal to the frame before
	logic extra_start [ROWS];

	nlc_top dut0 (.*);
	arith_models models0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [3:0] random_latency();
		logic [3:0] v;
		v = '0;
		for (int b = 0; b < 3; b++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[2:0], lfsr[0]};
		end
		return v + 4'd1;
	endfunction

	function automatic logic [31:0] model_result(input logic [`NLC_ADC_W-1:0] x, input int ch);
		logic [31:0] n;
		logic [31:0] acc;
		n = (32'(x) + shadow[ch][`NLC_IDX_NEG_MEAN]) * shadow[ch][`NLC_IDX_RECIP];
		acc = shadow[ch][`NLC_ORDER];
		for (int k = `NLC_ORDER - 1; k >= 0; k--)
			acc = acc * n + shadow[ch][k];
		return acc;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic set_row(input int i, input string name,
			input logic [`NLC_CHANNELS-1:0][`NLC_ADC_W-1:0] x, input logic [`NLC_CH_W-1:0] ch,
			input logic [31:0] base, input logic [`NLC_CHANNELS-1:0] keep_mask, input logic extra);
		names[i] = name;
		samples[i] = x;
		wr_chs[i] = ch;
		bases[i] = base;
		keep[i] = keep_mask;
		extra_start[i] = extra;
	endtask

	task automatic write_bank(input logic [`NLC_CH_W-1:0] ch, input logic [31:0] base);
		logic [31:0] word;
		for (int i = 0; i < WORDS; i++) begin
			word = base ^ (32'h9e3779b9 * (i + 1));
			@(posedge clk);
			coef_wr <= 1'b1;
			coef_ch <= ch;
			coef_idx <= `NLC_IDX_W'(i);
			coef_data <= word;
			shadow[ch][i] = word;
		end
		@(posedge clk);
		coef_wr <= 1'b0;
	endtask

	// Sampled on falling edges, away from the driving edge
	task automatic wait_result(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!result_valid && cycles < LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!result_valid) begin
			timeouts++;
			$display("Timeout in %s: no result within %0d cycles", name, LIMIT);
		end
	endtask

	task automatic run_row(input int i);
		string name;
		int extra;
		write_bank(wr_chs[i], bases[i]);
		for (int u = 0; u < 3; u++)
			latency[u] <= random_latency();
		@(posedge clk);
		start <= 1'b1;
		x_adc <= samples[i];
		@(posedge clk);
		start <= 1'b0;
		x_adc <= ~samples[i]; // Must not reach this frame
		for (int c = 0; c < `NLC_CHANNELS; c++) begin
			name = $sformatf("%s_ch%0d", names[i], c);
			wait_result(name);
			if (timeouts != 0)
				return;
			check_value({name, "_id"}, 32'(c), 32'(result_ch));
			check_value({name, "_busy"}, 32'd1, 32'(busy));
			check_value(name, model_result(samples[i][c], c), result);
			if (keep[i][c])
				check_value({name, "_same"}, prev[c], result);
			prev[c] = result;
			if (c == 0 && extra_start[i]) begin
				@(posedge clk);
				start <= 1'b1;
				@(posedge clk);
				start <= 1'b0;
			end
		end
		@(negedge clk);
		check_value({names[i], "_busy"}, 32'd0, 32'(busy));
		extra = 0;
		repeat (20) begin
			@(negedge clk);
			if (result_valid || busy)
				extra++;
		end
		check_value({names[i], "_idle"}, 32'd0, extra);
	endtask

	initial begin
		lfsr = 32'h4d3cdd70;
		checks = 0;
		errors = 0;
		timeouts = 0;
		rst <= 1'b1;
		start <= 1'b0;
		x_adc <= '0;
		coef_wr <= 1'b0;
		coef_ch <= '0;
		coef_idx <= '0;
		coef_data <= '0;
		latency <= {3{4'd1}};
		for (int c = 0; c < `NLC_CHANNELS; c++) begin
			prev[c] = '0;
			for (int i = 0; i < WORDS; i++)
				shadow[c][i] = '0;
		end
		set_row(0, "load_ch0", {21'h1f0e1d, 21'h0a5a5a, 21'h123456, 21'h00c0de}, 2'd0,
			32'h0000_0a31, 4'b0000, 1'b0);
		set_row(1, "load_ch1", {21'h1f0e1d, 21'h0a5a5a, 21'h123456, 21'h00c0de}, 2'd1,
			32'h0001_7c05, 4'b0000, 1'b0);
		set_row(2, "load_ch2", {21'h1f0e1d, 21'h0a5a5a, 21'h123456, 21'h00c0de}, 2'd2,
			32'h00c0_ffee, 4'b0000, 1'b0);
		set_row(3, "load_ch3", {21'h1f0e1d, 21'h0a5a5a, 21'h123456, 21'h00c0de}, 2'd3,
			32'h7fff_0003, 4'b0000, 1'b0);
		set_row(4, "latency_rerun", {21'h1f0e1d, 21'h0a5a5a, 21'h123456, 21'h00c0de}, 2'd3,
			32'h7fff_0003, 4'b1111, 1'b0);
		set_row(5, "busy_start", {21'h1f0e1d, 21'h0a5a5a, 21'h123456, 21'h00c0de}, 2'd1,
			32'h0bad_cafe, 4'b1101, 1'b1);
		set_row(6, "recapture", {21'h000001, 21'h1fffff, 21'h0badad, 21'h155555}, 2'd2,
			32'h3141_5926, 4'b0000, 1'b0);
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("reset", 32'd0, 32'({busy, result_valid, conv_req, add_req, mul_req}));
		for (int i = 0; i < ROWS && timeouts == 0; i++)
			run_row(i);
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: all.f
+incdir+verilog
verilog/nlc_pkg.sv
verilog/arith_if.sv
verilog/coef_bank.sv
verilog/arith_port.sv
verilog/nlc_sequencer.sv
verilog/nlc_top.sv
sim/arith_models.sv
sim/tb_nlc.sv

// File: Makefile
all: run

compile:
	verilator --binary --timing -f all.f --top-module tb_nlc -Mdir obj_dir -o sim_nlc

run: compile
	./obj_dir/sim_nlc | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
